//--- Makefile
# Verilator build and run for the integer core testbench

VERILATOR ?= verilator
TOP       ?= tb_int_core
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Everything OK

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/core_pkg.sv
package core_pkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int NUM_REGS    = 32;
    localparam int QUEUE_DEPTH = 4;
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);

    localparam logic [XLEN-1:0] RESET_PC = 32'hbfc0_0000;

    // primary opcode field, only the kept subset
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } op_e;

    // SPECIAL function field
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef struct packed {
        logic [XLEN-1:0] inst;
        logic [XLEN-1:0] pc;
    } fetch_t;

    // decode to execute
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        alu_op_e               alu_op;
        logic [XLEN-1:0]       op_a;
        logic [XLEN-1:0]       op_b;
        logic [4:0]            shamt;
        logic [REG_ADDR_W-1:0] dst;
        logic                  we;
    } exec_t;

    // execute to write-back, also the trace record
    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] dst;
        logic [XLEN-1:0]       data;
    } wb_t;

endpackage

//--- design/decode_stage.sv
module decode_stage
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  head_valid_i,
    input  fetch_t                head_i,
    input  logic [XLEN-1:0]       rs_data_i,
    input  logic [XLEN-1:0]       rt_data_i,
    input  logic                  ex_fwd_valid_i,
    input  wb_t                   ex_fwd_i,
    input  logic                  wb_valid_i,
    input  wb_t                   wb_i,
    output logic                  pop_o,
    output logic [REG_ADDR_W-1:0] rs_addr_o,
    output logic [REG_ADDR_W-1:0] rt_addr_o,
    output logic                  ex_valid_o,
    output exec_t                 ex_o
);

    op_e                   op;
    funct_e                funct;
    logic [REG_ADDR_W-1:0] rd_idx;
    logic [15:0]           imm;
    alu_op_e               alu_op;
    logic [XLEN-1:0]       imm_ext;
    logic [REG_ADDR_W-1:0] dst;
    logic                  use_imm;
    logic                  defined;
    logic [XLEN-1:0]       rs_val;
    logic [XLEN-1:0]       rt_val;
    exec_t                 ex_next;

    assign op        = op_e'(head_i.inst[31:26]);
    assign rs_addr_o = head_i.inst[25:21];
    assign rt_addr_o = head_i.inst[20:16];
    assign rd_idx    = head_i.inst[15:11];
    assign funct     = funct_e'(head_i.inst[5:0]);
    assign imm       = head_i.inst[15:0];

    // no stall so the head leaves as soon as it shows up
    assign pop_o = head_valid_i;

    always_comb begin
        alu_op  = ALU_ADD;
        imm_ext = {{16{imm[15]}}, imm};
        dst     = rt_addr_o;
        use_imm = 1'b1;
        defined = 1'b1;
        case (op)
            OP_SPECIAL: begin
                dst     = rd_idx;
                use_imm = 1'b0;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_NOR:  alu_op = ALU_NOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    FN_SLTU: alu_op = ALU_SLTU;
                    FN_SLL:  alu_op = ALU_SLL;
                    FN_SRL:  alu_op = ALU_SRL;
                    FN_SRA:  alu_op = ALU_SRA;
                    default: defined = 1'b0;
                endcase
            end
            OP_ADDIU: alu_op = ALU_ADD;
            OP_SLTI:  alu_op = ALU_SLT;
            OP_SLTIU: alu_op = ALU_SLTU;
            OP_ANDI: begin
                alu_op  = ALU_AND;
                imm_ext = {16'h0, imm};
            end
            OP_ORI: begin
                alu_op  = ALU_OR;
                imm_ext = {16'h0, imm};
            end
            OP_XORI: begin
                alu_op  = ALU_XOR;
                imm_ext = {16'h0, imm};
            end
            OP_LUI: begin
                alu_op  = ALU_LUI;
                imm_ext = {imm, 16'h0};
            end
            default: defined = 1'b0;
        endcase
    end

    // execute result first, then write-back, then register file
    function automatic logic [XLEN-1:0] fwd_sel(input logic [REG_ADDR_W-1:0] addr,
                                                input logic [XLEN-1:0] rf_val);
        logic [XLEN-1:0] val;
        if (addr == '0) begin
            val = '0;
        end else if (ex_fwd_valid_i && ex_fwd_i.dst == addr) begin
            val = ex_fwd_i.data;
        end else if (wb_valid_i && wb_i.dst == addr) begin
            val = wb_i.data;
        end else begin
            val = rf_val;
        end
        return val;
    endfunction

    always_comb begin
        rs_val = fwd_sel(rs_addr_o, rs_data_i);
        rt_val = fwd_sel(rt_addr_o, rt_data_i);
    end

    assign ex_next = '{
        pc:     head_i.pc,
        alu_op: alu_op,
        op_a:   rs_val,
        op_b:   use_imm ? imm_ext : rt_val,
        shamt:  head_i.inst[10:6],
        dst:    dst,
        we:     defined && (dst != '0)
    };

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_valid_o <= 1'b0;
        end else begin
            ex_valid_o <= head_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (head_valid_i) begin
            ex_o <= ex_next;
        end
    end

endmodule

//--- design/execute_stage.sv
module execute_stage
    import core_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  ex_valid_i,
    input  exec_t ex_i,
    output logic  fwd_valid_o,
    output wb_t   fwd_o,
    output logic  wb_valid_o,
    output wb_t   wb_o
);

    logic            is_shift;
    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] src_b;
    logic [4:0]      sa;
    logic [XLEN-1:0] result;

    // shifts take their amount from shamt and shift the rt operand
    assign is_shift = (ex_i.alu_op == ALU_SLL) || (ex_i.alu_op == ALU_SRL)
                   || (ex_i.alu_op == ALU_SRA);
    assign src_a    = is_shift ? {27'b0, ex_i.shamt} : ex_i.op_a;
    assign src_b    = ex_i.op_b;
    assign sa       = src_a[4:0];

    always_comb begin
        case (ex_i.alu_op)
            ALU_ADD:  result = src_a + src_b;
            ALU_SUB:  result = src_a - src_b;
            ALU_AND:  result = src_a & src_b;
            ALU_OR:   result = src_a | src_b;
            ALU_XOR:  result = src_a ^ src_b;
            ALU_NOR:  result = ~(src_a | src_b);
            ALU_SLT:  result = {31'b0, $signed(src_a) < $signed(src_b)};
            ALU_SLTU: result = {31'b0, src_a < src_b};
            ALU_SLL:  result = src_b << sa;
            ALU_SRL:  result = src_b >> sa;
            ALU_SRA:  result = $unsigned($signed(src_b) >>> sa);
            ALU_LUI:  result = src_b;
            default:  result = '0;
        endcase
    end

    // only writing instructions are visible to decode
    assign fwd_valid_o = ex_valid_i & ex_i.we;
    assign fwd_o       = '{pc: ex_i.pc, dst: ex_i.dst, data: result};

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= fwd_valid_o;
        end
    end

    always_ff @(posedge clk) begin
        if (fwd_valid_o) begin
            wb_o <= fwd_o;
        end
    end

endmodule

//--- design/inst_queue.sv
module inst_queue
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            inst_valid_i,
    input  logic [XLEN-1:0] inst_data_i,
    input  logic            pop_i,
    output logic            inst_ready_o,
    output logic            head_valid_o,
    output fetch_t          head_o
);

    fetch_t             mem [QUEUE_DEPTH];
    logic [QPTR_W-1:0]  wr_ptr;
    logic [QPTR_W-1:0]  rd_ptr;
    logic [QCNT_W-1:0]  count;
    logic [XLEN-1:0]    pc_cnt;
    logic               push;
    logic               pop;

    assign inst_ready_o = (count != QCNT_W'(QUEUE_DEPTH));
    assign head_valid_o = (count != '0);
    assign head_o       = mem[rd_ptr];

    assign push = inst_valid_i & inst_ready_o;
    assign pop  = pop_i & head_valid_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            pc_cnt <= RESET_PC;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                pc_cnt <= pc_cnt + 32'd4;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave the count unchanged
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (!push && pop) begin
                count <= count - 1'b1;
            end
        end
    end

    // entry payload, tagged with its pc
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= '{inst: inst_data_i, pc: pc_cnt};
        end
    end

endmodule

//--- design/int_core.sv
module int_core
    import core_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            inst_valid_i,
    input  logic [XLEN-1:0] inst_data_i,
    output logic            inst_ready_o,
    output logic            wb_valid_o,
    output wb_t             wb_o
);

    logic                  head_valid;
    fetch_t                head;
    logic                  pop;
    logic [REG_ADDR_W-1:0] rs_addr;
    logic [REG_ADDR_W-1:0] rt_addr;
    logic [XLEN-1:0]       rs_data;
    logic [XLEN-1:0]       rt_data;
    logic                  ex_valid;
    exec_t                 ex;
    logic                  fwd_valid;
    wb_t                   fwd;

    inst_queue u_inst_queue (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_data_i  (inst_data_i),
        .pop_i        (pop),
        .inst_ready_o (inst_ready_o),
        .head_valid_o (head_valid),
        .head_o       (head)
    );

    decode_stage u_decode_stage (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .head_valid_i   (head_valid),
        .head_i         (head),
        .rs_data_i      (rs_data),
        .rt_data_i      (rt_data),
        .ex_fwd_valid_i (fwd_valid),
        .ex_fwd_i       (fwd),
        .wb_valid_i     (wb_valid_o),
        .wb_i           (wb_o),
        .pop_o          (pop),
        .rs_addr_o      (rs_addr),
        .rt_addr_o      (rt_addr),
        .ex_valid_o     (ex_valid),
        .ex_o           (ex)
    );

    execute_stage u_execute_stage (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .ex_valid_i  (ex_valid),
        .ex_i        (ex),
        .fwd_valid_o (fwd_valid),
        .fwd_o       (fwd),
        .wb_valid_o  (wb_valid_o),
        .wb_o        (wb_o)
    );

    // write-back register doubles as the trace port
    regfile u_regfile (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .we_i      (wb_valid_o),
        .wb_i      (wb_o),
        .rs_addr_i (rs_addr),
        .rt_addr_i (rt_addr),
        .rs_data_o (rs_data),
        .rt_data_o (rt_data)
    );

endmodule

//--- design/regfile.sv
module regfile
    import core_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  we_i,
    input  wb_t                   wb_i,
    input  logic [REG_ADDR_W-1:0] rs_addr_i,
    input  logic [REG_ADDR_W-1:0] rt_addr_i,
    output logic [XLEN-1:0]       rs_data_o,
    output logic [XLEN-1:0]       rt_data_o
);

    logic [XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && wb_i.dst != '0) begin
            regs[wb_i.dst] <= wb_i.data;
        end
    end

    // old value during a write, decode forwards the new one
    assign rs_data_o = regs[rs_addr_i];
    assign rt_data_o = regs[rt_addr_i];

endmodule

//--- files.f
design/core_pkg.sv
design/inst_queue.sv
design/decode_stage.sv
design/execute_stage.sv
design/regfile.sv
design/int_core.sv
test/tb_int_core.sv

//--- test/tb_int_core.sv
module tb_int_core
    import core_pkg::*;
();

    localparam int N_DIRECTED = 29;
    localparam int N_RANDOM   = 400;
    localparam int MAX_CYCLES = 20 * (N_DIRECTED + N_RANDOM) + 200;

    localparam logic [5:0] FN_TAB [11] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
                                           FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA};
    localparam logic [5:0] OP_TAB [7]  = '{OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI,
                                           OP_XORI, OP_LUI};

    logic            clk;
    logic            rst_n_i;
    logic            inst_valid_i;
    logic [XLEN-1:0] inst_data_i;
    logic            inst_ready_o;
    logic            wb_valid_o;
    wb_t             wb_o;

    // reference state in program order
    logic [XLEN-1:0] mregs [NUM_REGS];
    logic [XLEN-1:0] m_pc;
    logic [31:0]     lcg_state;
    wb_t             exp_q [$];
    int              cycles;
    int              drain;

    int_core int_core_inst (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_data_i  (inst_data_i),
        .inst_ready_o (inst_ready_o),
        .wb_valid_o   (wb_valid_o),
        .wb_o         (wb_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles <= MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the test did not finish within %0d cycles", MAX_CYCLES);
        $display("Something failed");
        $fatal(1);
    end

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    function automatic logic [31:0] enc_r(input logic [5:0] fn, input int rs, input int rt,
                                          input int rd, input int sa);
        return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'(sa), fn};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input int rs, input int rt,
                                          input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    // small register range so that dependencies and r0 writes are frequent
    function automatic logic [31:0] rand_word();
        int sel;
        int rs;
        int rt;
        int rd;
        sel = int'(lcg_next() % 16'd20);
        rs  = int'(lcg_next() % 16'd8);
        rt  = int'(lcg_next() % 16'd8);
        rd  = int'(lcg_next() % 16'd8);
        if (sel < 11) begin
            return enc_r(FN_TAB[sel], rs, rt, rd, int'(lcg_next() % 16'd32));
        end else if (sel < 18) begin
            return enc_i(OP_TAB[sel - 11], rs, rt, lcg_next());
        end else if (sel == 18) begin
            return {6'h3f, 10'(lcg_next()), lcg_next()};
        end
        return enc_r(6'h3f, rs, rt, rd, 0);
    endfunction

    // builds the expected trace record and returns 0 when the word must not write
    function automatic bit ref_result(input logic [31:0] word, input logic [31:0] pc,
                                      output wb_t rec);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sx;
        logic [31:0] zx;
        logic [31:0] res;
        logic [4:0]  dst;
        bit          ok;
        a   = mregs[word[25:21]];
        b   = mregs[word[20:16]];
        sx  = {{16{word[15]}}, word[15:0]};
        zx  = {16'h0000, word[15:0]};
        res = '0;
        dst = word[20:16];
        ok  = 1'b1;
        case (word[31:26])
            OP_SPECIAL: begin
                dst = word[15:11];
                case (word[5:0])
                    FN_ADDU: res = a + b;
                    FN_SUBU: res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_XOR:  res = a ^ b;
                    FN_NOR:  res = ~(a | b);
                    FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
                    FN_SLL:  res = b << word[10:6];
                    FN_SRL:  res = b >> word[10:6];
                    FN_SRA:  res = (b >> word[10:6])
                                 | (b[31] ? ~(32'hffff_ffff >> word[10:6]) : 32'h0);
                    default: ok = 1'b0;
                endcase
            end
            OP_ADDIU: res = a + sx;
            OP_SLTI:  res = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
            OP_SLTIU: res = (a < sx) ? 32'd1 : 32'd0;
            OP_ANDI:  res = a & zx;
            OP_ORI:   res = a | zx;
            OP_XORI:  res = a ^ zx;
            OP_LUI:   res = {word[15:0], 16'h0000};
            default:  ok = 1'b0;
        endcase
        rec = '{pc: pc, dst: dst, data: res};
        return ok && (dst != 5'd0);
    endfunction

    task automatic check_wb(input wb_t got, input wb_t exp);
        if (got !== exp) begin
            $display("ERROR @%0t: trace got pc %h dst %0d data %h, expected pc %h dst %0d data %h",
                     $time, got.pc, got.dst, got.data, exp.pc, exp.dst, exp.data);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic check_ready(input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR @%0t: inst_ready_o is %b, expected %b", $time, got, exp);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    task automatic check_trace_valid(input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR @%0t: wb_valid_o is %b, expected %b", $time, got, exp);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    // drives one word through the handshake and updates the model
    task automatic push_word(input logic [31:0] word);
        wb_t rec;
        inst_valid_i = 1'b1;
        inst_data_i  = word;
        @(negedge clk);
        // decode pops every cycle so the queue never fills
        check_ready(inst_ready_o, 1'b1);
        @(posedge clk);
        #1;
        if (ref_result(word, m_pc, rec)) begin
            exp_q.push_back(rec);
            mregs[rec.dst] = rec.data;
        end
        m_pc = m_pc + 32'd4;
    endtask

    task automatic idle_cycles(input int n);
        inst_valid_i = 1'b0;
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic check_drained();
        idle_cycles(QUEUE_DEPTH + 2);
        @(negedge clk);
        check_ready(inst_ready_o, 1'b1);
        check_trace_valid(wb_valid_o, 1'b0);
        @(posedge clk);
        #1;
    endtask

    always @(negedge clk) begin
        if (rst_n_i && wb_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("ERROR @%0t: trace entry pc %h with no expected entry", $time, wb_o.pc);
                $display("Something failed");
                $fatal(1);
            end else begin
                check_wb(wb_o, exp_q.pop_front());
            end
        end
    end

    initial begin
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_data_i  = '0;
        m_pc         = RESET_PC;
        lcg_state    = 32'h2e76;
        for (int i = 0; i < NUM_REGS; i++) begin
            mregs[i] = '0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        @(negedge clk);
        check_ready(inst_ready_o, 1'b1);
        check_trace_valid(wb_valid_o, 1'b0);
        @(posedge clk);
        #1;

        // every operation with sign and zero extension corners
        push_word(enc_i(OP_LUI, 0, 1, 16'h8000));
        push_word(enc_i(OP_ORI, 1, 1, 16'h8234));
        push_word(enc_i(OP_ADDIU, 0, 2, 16'hffff));
        push_word(enc_i(OP_ANDI, 2, 3, 16'hff00));
        push_word(enc_i(OP_XORI, 2, 4, 16'h8001));
        push_word(enc_i(OP_SLTI, 1, 5, 16'hffff));
        push_word(enc_i(OP_SLTIU, 1, 6, 16'hffff));
        push_word(enc_r(FN_SLT, 2, 3, 7, 0));
        push_word(enc_r(FN_SLTU, 2, 3, 7, 0));
        push_word(enc_r(FN_ADDU, 1, 2, 4, 0));
        push_word(enc_r(FN_SUBU, 3, 1, 5, 0));
        push_word(enc_r(FN_AND, 1, 4, 6, 0));
        push_word(enc_r(FN_OR, 2, 3, 7, 0));
        push_word(enc_r(FN_XOR, 5, 6, 4, 0));
        push_word(enc_r(FN_NOR, 3, 0, 5, 0));
        push_word(enc_r(FN_SLL, 0, 1, 6, 4));
        push_word(enc_r(FN_SRL, 0, 1, 7, 31));
        push_word(enc_r(FN_SRA, 0, 1, 4, 8));
        idle_cycles(3);

        // accumulate through the execute forward
        repeat (5) push_word(enc_i(OP_ADDIU, 8, 8, 16'h0011));
        push_word(enc_r(FN_ADDU, 8, 8, 9, 0));
        check_drained();

        // r0 and undefined words leave no trace but still take a pc
        push_word(enc_i(OP_ADDIU, 1, 0, 16'h0005));
        push_word(enc_r(FN_ADDU, 2, 3, 0, 0));
        push_word({6'h3f, 26'h123_4567});
        push_word(enc_r(6'h3f, 1, 2, 3, 0));
        push_word(enc_r(FN_OR, 0, 1, 10, 0));
        check_drained();

        for (int i = 0; i < N_RANDOM; i++) begin
            push_word(rand_word());
            if (lcg_next() % 16'd8 == 16'd0) begin
                idle_cycles(int'(lcg_next() % 16'd3) + 1);
            end
            if (i % 50 == 49) begin
                check_drained();
            end
        end

        idle_cycles(2);
        drain = 0;
        while (exp_q.size() != 0 && drain < 100) begin
            @(posedge clk);
            drain++;
        end
        repeat (10) @(posedge clk);
        if (exp_q.size() == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("%0d expected trace entries never appeared", exp_q.size());
            $display("Something failed");
            $fatal(1);
        end
    end

endmodule
